/* common/fpAddPkg.sv */
`default_nettype none

package fpAddPkg;

  //////////////////////////////
  // Field widths
  //////////////////////////////

  // Single precision word
  localparam int WORD_W = 32;
  localparam int EXP_W = 8;
  localparam int MANT_W = 23;

  // Guard bits below the mantissa during alignment
  localparam int GUARD_W = 2;

  // Hidden one, mantissa and guard bits
  localparam int SIG_W = 1 + MANT_W + GUARD_W;

  // Shift amounts and leading-zero count
  localparam int SHIFT_W = 5;

  // All-ones exponent marks saturation
  localparam int EXP_MAX = 255;

  //////////////////////////////
  // Stage-to-stage payloads
  //////////////////////////////

  // Sort stage to align stage
  typedef struct packed {
    logic               valid;
    logic [EXP_W-1:0]   exponent;
    logic [MANT_W-1:0]  mantLarge;
    logic [MANT_W-1:0]  mantSmall;
    logic [SHIFT_W-1:0] expDiff;
    logic               effSub;
    logic               sign;
    logic               zero;
  } sortedOps_t;

  // Align stage to adder stage
  typedef struct packed {
    logic             valid;
    logic [EXP_W-1:0] exponent;
    logic [SIG_W-1:0] sigLarge;
    logic [SIG_W-1:0] sigSmall;
    logic             effSub;
    logic             sign;
    logic             zero;
  } alignedOps_t;

  // Adder stage to normalize stage
  typedef struct packed {
    logic             valid;
    logic [EXP_W-1:0] exponent;
    logic [SIG_W-1:0] rawSig;
    logic             carry;
    logic             sign;
    logic             zero;
  } sumResult_t;

  // Normalize stage to format stage, exponent may go negative
  typedef struct packed {
    logic                    valid;
    logic signed [EXP_W:0]   exponent;
    logic [MANT_W-1:0]       mantissa;
    logic                    sign;
    logic                    zero;
  } normResult_t;

endpackage

`default_nettype wire

/* design/operandSort.sv */
`timescale 1ns/1ps
`default_nettype none

module operandSort
  import fpAddPkg::*;
(
  input  logic              clk,
  input  logic              reset_i,
  input  logic              startOp_i,
  input  logic              addSub_i,
  input  logic [WORD_W-1:0] dataX_i,
  input  logic [WORD_W-1:0] dataY_i,
  output sortedOps_t        sorted_o
);

  logic              xGreater;
  logic              magEqual;
  logic              effSub;
  logic              signRes;
  logic [WORD_W-2:0] magLarge;
  logic [WORD_W-2:0] magSmall;
  logic [EXP_W-1:0]  expDiffFull;
  sortedOps_t        sortedNext;

  //////////////////////////////
  // Magnitude compare
  //////////////////////////////

  // Exponent over mantissa so the low 31 bits order as magnitudes
  assign xGreater = dataX_i[WORD_W-2:0] > dataY_i[WORD_W-2:0];
  assign magEqual = dataX_i[WORD_W-2:0] == dataY_i[WORD_W-2:0];

  // Larger operand goes first, Y wins ties
  assign magLarge = xGreater ? dataX_i[WORD_W-2:0] : dataY_i[WORD_W-2:0];
  assign magSmall = xGreater ? dataY_i[WORD_W-2:0] : dataX_i[WORD_W-2:0];

  // Real operation after both signs and the requested op
  assign effSub = dataX_i[WORD_W-1] ^ dataY_i[WORD_W-1] ^ addSub_i;

  // Y contributes with its sign flipped on subtract
  assign signRes = xGreater ? dataX_i[WORD_W-1] : (dataY_i[WORD_W-1] ^ addSub_i);

  // Never negative since the larger magnitude has the larger exponent
  assign expDiffFull = magLarge[WORD_W-2 -: EXP_W] - magSmall[WORD_W-2 -: EXP_W];

  //////////////////////////////
  // Next stage payload
  //////////////////////////////
  always_comb begin
    sortedNext.valid     = startOp_i;
    sortedNext.exponent  = magLarge[WORD_W-2 -: EXP_W];
    sortedNext.mantLarge = magLarge[MANT_W-1:0];
    sortedNext.mantSmall = magSmall[MANT_W-1:0];
    // Saturate, anything past the significand width vanishes anyway
    if (expDiffFull > EXP_W'((1 << SHIFT_W) - 1)) begin
      sortedNext.expDiff = '1;
    end else begin
      sortedNext.expDiff = expDiffFull[SHIFT_W-1:0];
    end
    sortedNext.effSub    = effSub;
    sortedNext.sign      = signRes;
    // Exact cancellation
    sortedNext.zero      = effSub & magEqual;
  end

  // Stage register
  always_ff @(posedge clk) begin
    if (reset_i) begin
      sorted_o.valid <= 1'b0;
    end else begin
      sorted_o <= sortedNext;
    end
  end

endmodule

`default_nettype wire

/* design/alignStage.sv */
`timescale 1ns/1ps
`default_nettype none

module alignStage
  import fpAddPkg::*;
(
  input  logic        clk,
  input  logic        reset_i,
  input  sortedOps_t  sorted_i,
  output alignedOps_t aligned_o
);

  logic [SIG_W-1:0] sigLarge;
  logic [SIG_W-1:0] shiftLevel [SHIFT_W+1];
  alignedOps_t      alignedNext;

  // Hidden one on top, guard bits below
  assign sigLarge      = {1'b1, sorted_i.mantLarge, {GUARD_W{1'b0}}};
  assign shiftLevel[0] = {1'b1, sorted_i.mantSmall, {GUARD_W{1'b0}}};

  //////////////////////////////
  // Log barrel shifter
  //////////////////////////////

  // One level per bit of the difference
  // Level k moves by 2**k, bits falling off the bottom are lost
  for (genvar k = 0; k < SHIFT_W; k++) begin : gShiftLevel
    assign shiftLevel[k+1] = sorted_i.expDiff[k] ? (shiftLevel[k] >> (2 ** k))
                                                  : shiftLevel[k];
  end

  always_comb begin
    alignedNext.valid    = sorted_i.valid;
    alignedNext.exponent = sorted_i.exponent;
    alignedNext.sigLarge = sigLarge;
    alignedNext.sigSmall = shiftLevel[SHIFT_W];
    alignedNext.effSub   = sorted_i.effSub;
    alignedNext.sign     = sorted_i.sign;
    alignedNext.zero     = sorted_i.zero;
  end

  // Stage register
  always_ff @(posedge clk) begin
    if (reset_i) begin
      aligned_o.valid <= 1'b0;
    end else begin
      aligned_o <= alignedNext;
    end
  end

endmodule

`default_nettype wire

/* design/significandAdder.sv */
`timescale 1ns/1ps
`default_nettype none

module significandAdder
  import fpAddPkg::*;
(
  input  logic        clk,
  input  logic        reset_i,
  input  alignedOps_t aligned_i,
  output sumResult_t  sum_o
);

  // One extra bit on top for the carry out
  logic [SIG_W:0] sigWide;
  sumResult_t     sumNext;

  //////////////////////////////
  // Significand add or subtract
  //////////////////////////////

  // Larger minus smaller never borrows
  assign sigWide = aligned_i.effSub ? ({1'b0, aligned_i.sigLarge} - {1'b0, aligned_i.sigSmall})
                                    : ({1'b0, aligned_i.sigLarge} + {1'b0, aligned_i.sigSmall});

  always_comb begin
    sumNext.valid    = aligned_i.valid;
    sumNext.exponent = aligned_i.exponent;
    sumNext.rawSig   = sigWide[SIG_W-1:0];
    // Carry only means something on an effective add
    sumNext.carry    = sigWide[SIG_W] & ~aligned_i.effSub;
    sumNext.sign     = aligned_i.sign;
    sumNext.zero     = aligned_i.zero;
  end

  // Stage register
  always_ff @(posedge clk) begin
    if (reset_i) begin
      sum_o.valid <= 1'b0;
    end else begin
      sum_o <= sumNext;
    end
  end

endmodule

`default_nettype wire

/* normalize/leadingZeroCount.sv */
`timescale 1ns/1ps
`default_nettype none

module leadingZeroCount
  import fpAddPkg::*;
(
  input  logic [SIG_W-1:0]   sig_i,
  output logic [SHIFT_W-1:0] count_o
);

  //////////////////////////////
  // Priority encoder
  //////////////////////////////

  // Scan upward so the highest set bit wins
  // All zeros reports the largest count, only seen on exact cancellation
  always_comb begin
    count_o = SHIFT_W'(SIG_W - 1);
    for (int i = 0; i < SIG_W; i++) begin
      if (sig_i[i]) begin
        count_o = SHIFT_W'(SIG_W - 1 - i);
      end
    end
  end

endmodule

`default_nettype wire

/* normalize/normalizeStage.sv */
`timescale 1ns/1ps
`default_nettype none

module normalizeStage
  import fpAddPkg::*;
(
  input  logic        clk,
  input  logic        reset_i,
  input  sumResult_t  sum_i,
  output normResult_t norm_o
);

  logic [SHIFT_W-1:0]    lzCount;
  logic [SIG_W-1:0]      sigNorm;
  logic signed [EXP_W:0] expBase;
  logic signed [EXP_W:0] expAdjusted;
  normResult_t           normNext;

  // Zeros above the leading one
  leadingZeroCount lzcInst (
    .sig_i   (sum_i.rawSig),
    .count_o (lzCount)
  );

  //////////////////////////////
  // Normalizing shift
  //////////////////////////////

  // Carry re-enters at the top on a one-bit right shift
  // Otherwise pull the leading one up to the top
  assign sigNorm = sum_i.carry ? {1'b1, sum_i.rawSig[SIG_W-1:1]}
                               : (sum_i.rawSig << lzCount);

  //////////////////////////////
  // Exponent adjust
  //////////////////////////////

  // Widened and signed so underflow shows as zero or below
  assign expBase = $signed({1'b0, sum_i.exponent});

  always_comb begin
    if (sum_i.carry) begin
      expAdjusted = expBase + (EXP_W+1)'(1);
    end else begin
      expAdjusted = expBase - $signed({{(EXP_W+1-SHIFT_W){1'b0}}, lzCount});
    end
  end

  always_comb begin
    normNext.valid    = sum_i.valid;
    normNext.exponent = expAdjusted;
    // Drop the hidden bit and the guard bits
    normNext.mantissa = sigNorm[SIG_W-2 -: MANT_W];
    normNext.sign     = sum_i.sign;
    normNext.zero     = sum_i.zero;
  end

  // Stage register
  always_ff @(posedge clk) begin
    if (reset_i) begin
      norm_o.valid <= 1'b0;
    end else begin
      norm_o <= normNext;
    end
  end

endmodule

`default_nettype wire

/* design/resultFormat.sv */
`timescale 1ns/1ps
`default_nettype none

module resultFormat
  import fpAddPkg::*;
(
  input  logic              clk,
  input  logic              reset_i,
  input  normResult_t       norm_i,
  output logic [WORD_W-1:0] result_o,
  output logic              ready_o,
  output logic              overflow_o,
  output logic              underflow_o,
  output logic              zero_o
);

  logic              expOverflow;
  logic              expUnderflow;
  logic [WORD_W-1:0] wordNext;

  //////////////////////////////
  // Range checks
  //////////////////////////////

  // Cancellation wins over both range flags
  assign expOverflow  = ~norm_i.zero & (norm_i.exponent >= EXP_MAX);
  assign expUnderflow = ~norm_i.zero & (norm_i.exponent <= 0);

  // Word select, zero then saturate then flush then normal
  always_comb begin
    if (norm_i.zero) begin
      wordNext = '0;
    end else if (expOverflow) begin
      wordNext = {norm_i.sign, {EXP_W{1'b1}}, {MANT_W{1'b0}}};
    end else if (expUnderflow) begin
      wordNext = {norm_i.sign, {(WORD_W-1){1'b0}}};
    end else begin
      wordNext = {norm_i.sign, norm_i.exponent[EXP_W-1:0], norm_i.mantissa};
    end
  end

  //////////////////////////////
  // Output register
  //////////////////////////////

  // Word and flags only change with a valid result
  always_ff @(posedge clk) begin
    if (reset_i) begin
      result_o    <= '0;
      ready_o     <= 1'b0;
      overflow_o  <= 1'b0;
      underflow_o <= 1'b0;
      zero_o      <= 1'b0;
    end else begin
      ready_o <= norm_i.valid;
      if (norm_i.valid) begin
        result_o    <= wordNext;
        overflow_o  <= expOverflow;
        underflow_o <= expUnderflow;
        zero_o      <= norm_i.zero;
      end
    end
  end

endmodule

`default_nettype wire

/* design/fpAddSub.sv */
`timescale 1ns/1ps
`default_nettype none

module fpAddSub
  import fpAddPkg::*;
(
  input  logic              clk,
  input  logic              reset_i,
  input  logic              startOp_i,
  input  logic              addSub_i,
  input  logic [WORD_W-1:0] dataX_i,
  input  logic [WORD_W-1:0] dataY_i,
  output logic [WORD_W-1:0] result_o,
  output logic              ready_o,
  output logic              overflow_o,
  output logic              underflow_o,
  output logic              zero_o
);

  // Stage registers between the five stages
  sortedOps_t  sortedOps;
  alignedOps_t alignedOps;
  sumResult_t  sumResult;
  normResult_t normResult;

  //////////////////////////////
  // Stage 1 sort and compare
  //////////////////////////////
  operandSort sortInst (
    .clk       (clk),
    .reset_i   (reset_i),
    .startOp_i (startOp_i),
    .addSub_i  (addSub_i),
    .dataX_i   (dataX_i),
    .dataY_i   (dataY_i),
    .sorted_o  (sortedOps)
  );

  // Stage 2 right alignment
  alignStage alignInst (
    .clk       (clk),
    .reset_i   (reset_i),
    .sorted_i  (sortedOps),
    .aligned_o (alignedOps)
  );

  // Stage 3 significand add or subtract
  significandAdder adderInst (
    .clk       (clk),
    .reset_i   (reset_i),
    .aligned_i (alignedOps),
    .sum_o     (sumResult)
  );

  // Stage 4 normalization
  normalizeStage normInst (
    .clk     (clk),
    .reset_i (reset_i),
    .sum_i   (sumResult),
    .norm_o  (normResult)
  );

  // Stage 5 packing and flags
  resultFormat formatInst (
    .clk         (clk),
    .reset_i     (reset_i),
    .norm_i      (normResult),
    .result_o    (result_o),
    .ready_o     (ready_o),
    .overflow_o  (overflow_o),
    .underflow_o (underflow_o),
    .zero_o      (zero_o)
  );

endmodule

`default_nettype wire

/* sim/fpRefModel.svh */
`ifndef FP_REF_MODEL_SVH
`define FP_REF_MODEL_SVH

// Expected word and flags of one operation
typedef struct packed {
  logic [WORD_W-1:0] result;
  logic              overflow;
  logic              underflow;
  logic              zero;
} fpOutcome_t;

// Truncating single precision add or subtract without rounding
function automatic fpOutcome_t modelAddSub(
  input logic [WORD_W-1:0] x,
  input logic [WORD_W-1:0] y,
  input logic              sub
);
  fpOutcome_t        outcome;
  logic              effSub;
  logic              xLarger;
  logic              sign;
  logic [WORD_W-1:0] opLarge;
  logic [WORD_W-1:0] opSmall;
  logic [SIG_W:0]    sigLarge;
  logic [SIG_W:0]    sigSmall;
  logic [SIG_W:0]    sum;
  int                expLarge;
  int                expOut;
  outcome = '0;
  effSub  = x[WORD_W-1] ^ y[WORD_W-1] ^ sub;
  xLarger = x[WORD_W-2:0] > y[WORD_W-2:0];
  opLarge = xLarger ? x : y;
  opSmall = xLarger ? y : x;
  // Exact cancellation gives plain positive zero
  if (effSub && (x[WORD_W-2:0] == y[WORD_W-2:0])) begin
    outcome.zero = 1'b1;
    return outcome;
  end
  sign     = xLarger ? x[WORD_W-1] : (y[WORD_W-1] ^ sub);
  expLarge = int'(opLarge[WORD_W-2 -: EXP_W]);
  // Hidden one, mantissa, guard bits, spare bit on top for the carry
  sigLarge = {1'b0, 1'b1, opLarge[MANT_W-1:0], {GUARD_W{1'b0}}};
  sigSmall = {1'b0, 1'b1, opSmall[MANT_W-1:0], {GUARD_W{1'b0}}};
  sigSmall = sigSmall >> (expLarge - int'(opSmall[WORD_W-2 -: EXP_W]));
  sum      = effSub ? (sigLarge - sigSmall) : (sigLarge + sigSmall);
  expOut   = expLarge;
  if (sum[SIG_W]) begin
    sum    = sum >> 1;
    expOut = expOut + 1;
  end else begin
    // Walk the leading one up to the hidden position
    for (int i = 0; (i < SIG_W) && !sum[SIG_W-1]; i++) begin
      sum    = sum << 1;
      expOut = expOut - 1;
    end
  end
  outcome.overflow  = expOut >= EXP_MAX;
  outcome.underflow = expOut <= 0;
  if (outcome.overflow) begin
    outcome.result = {sign, {EXP_W{1'b1}}, {MANT_W{1'b0}}};
  end else if (outcome.underflow) begin
    outcome.result = {sign, {(WORD_W-1){1'b0}}};
  end else begin
    outcome.result = {sign, EXP_W'(expOut), sum[SIG_W-2 -: MANT_W]};
  end
  return outcome;
endfunction

`endif

/* sim/fpAddSubTb.sv */
`timescale 1ns/1ps
`default_nettype none

module fpAddSubTb
  import fpAddPkg::*;
();

  `include "fpRefModel.svh"

  typedef enum int {opAdd, opSub, opCancel, opOverflow, opUnderflow, opMixed} opKind_t;

  // Model response and the negedge count where ready_o must show
  typedef struct packed {
    fpOutcome_t outcome;
    int         readyAt;
  } pendingOp_t;

  localparam int DRAIN_LIMIT = 200;

  logic              clk = 1'b0;
  logic              reset_i;
  logic              startOp_i;
  logic              addSub_i;
  logic [WORD_W-1:0] dataX_i;
  logic [WORD_W-1:0] dataY_i;
  logic [WORD_W-1:0] result_o;
  logic              ready_o;
  logic              overflow_o;
  logic              underflow_o;
  logic              zero_o;

  int         seed = 32'h103a541c;
  int         cycle = 0;
  int         errors = 0;
  int         testErrors = 0;
  int         testCount = 0;
  int         opCount = 0;
  bit         timedOut = 1'b0;
  string      testName = "reset";
  pendingOp_t pending [$];

  fpAddSub UUT (
    .clk         (clk),
    .reset_i     (reset_i),
    .startOp_i   (startOp_i),
    .addSub_i    (addSub_i),
    .dataX_i     (dataX_i),
    .dataY_i     (dataY_i),
    .result_o    (result_o),
    .ready_o     (ready_o),
    .overflow_o  (overflow_o),
    .underflow_o (underflow_o),
    .zero_o      (zero_o)
  );

  // 4 ns clock
  always #2 clk = ~clk;

  function automatic int randomInRange(input int lo, input int hi);
    return lo + int'($unsigned($random(seed)) % (hi - lo + 1));
  endfunction

  task automatic countError();
    errors++;
    testErrors++;
  endtask

  //////////////////////////////
  // Response checking
  //////////////////////////////
  task automatic checkOutcome(input pendingOp_t op);
    assert (result_o === op.outcome.result) else begin
      $display("FAIL %s result expected %h actual %h", testName, op.outcome.result, result_o);
      countError();
    end
    assert (overflow_o === op.outcome.overflow) else begin
      $display("FAIL %s overflow expected %b actual %b", testName, op.outcome.overflow,
               overflow_o);
      countError();
    end
    assert (underflow_o === op.outcome.underflow) else begin
      $display("FAIL %s underflow expected %b actual %b", testName, op.outcome.underflow,
               underflow_o);
      countError();
    end
    assert (zero_o === op.outcome.zero) else begin
      $display("FAIL %s zero expected %b actual %b", testName, op.outcome.zero, zero_o);
      countError();
    end
    assert (cycle == op.readyAt) else begin
      $display("FAIL %s ready cycle expected %0d actual %0d", testName, op.readyAt, cycle);
      countError();
    end
  endtask

  // Outputs settle away from the rising edge
  always @(negedge clk) begin
    cycle = cycle + 1;
    if (!reset_i) begin
      if (ready_o) begin
        assert (pending.size() != 0) else begin
          $display("Error in %s: ready_o pulsed with no operation outstanding", testName);
          countError();
        end
        if (pending.size() != 0) begin
          checkOutcome(pending.pop_front());
        end
      end else if (pending.size() != 0) begin
        assert (pending[0].readyAt > cycle) else begin
          $display("Error in %s: ready_o missing at cycle %0d", testName, pending[0].readyAt);
          countError();
          pending.delete(0);
        end
      end
    end
  end

  //////////////////////////////
  // Stimulus
  //////////////////////////////
  task automatic makeOperands(
    input  opKind_t           kind,
    output logic [WORD_W-1:0] x,
    output logic [WORD_W-1:0] y,
    output logic              sub
  );
    opKind_t           pick;
    logic              signX;
    logic              signY;
    int                expX;
    int                expY;
    int                diff;
    logic [MANT_W-1:0] mantX;
    logic [MANT_W-1:0] mantY;
    pick = kind;
    if (kind == opMixed) begin
      pick = (randomInRange(0, 1) != 0) ? opSub : opAdd;
    end
    sub   = randomInRange(0, 1) != 0;
    signX = randomInRange(0, 1) != 0;
    mantX = MANT_W'($random(seed));
    mantY = MANT_W'($random(seed));
    // Effective add unless a case below flips it
    signY = signX ^ sub;
    expX  = randomInRange(64, 190);
    expY  = randomInRange(64, 190);
    case (pick)
      opSub: begin
        signY = signX ^ sub ^ 1'b1;
        expX  = randomInRange(41, 200);
        // Deep cancellation, ordinary, or smaller operand gone
        case (randomInRange(0, 2))
          0: diff = randomInRange(0, 2);
          1: diff = randomInRange(3, 30);
          default: diff = randomInRange(32, 40);
        endcase
        expY = expX - diff;
        if (randomInRange(0, 1) != 0) begin
          expY = expX;
          expX = expX - diff;
        end
      end
      opCancel: begin
        signY = signX ^ sub ^ 1'b1;
        expY  = expX;
        mantY = mantX;
      end
      opOverflow: begin
        expX = 254;
        expY = 254;
      end
      opUnderflow: begin
        signY = signX ^ sub ^ 1'b1;
        expX  = 1;
        expY  = 1;
        // Nonzero flip keeps the magnitudes apart
        mantY = mantX ^ MANT_W'(randomInRange(1, 255));
      end
      default: ;
    endcase
    x = {signX, EXP_W'(expX), mantX};
    y = {signY, EXP_W'(expY), mantY};
  endtask

  task automatic idleCycle();
    @(posedge clk);
    startOp_i <= 1'b0;
  endtask

  task automatic issueOp(input opKind_t kind);
    logic [WORD_W-1:0] x;
    logic [WORD_W-1:0] y;
    logic              sub;
    pendingOp_t        op;
    makeOperands(kind, x, y, sub);
    @(posedge clk);
    startOp_i <= 1'b1;
    dataX_i   <= x;
    dataY_i   <= y;
    addSub_i  <= sub;
    op.outcome = modelAddSub(x, y, sub);
    // Sampled one edge later, then five stage edges
    op.readyAt = cycle + 6;
    pending.push_back(op);
    opCount++;
  endtask

  task automatic runTest(input string name, input opKind_t kind, input int count,
                         input int maxGap);
    int gap;
    int waited;
    testName   = name;
    testErrors = 0;
    for (int n = 0; n < count; n++) begin
      issueOp(kind);
      gap = randomInRange(0, maxGap);
      repeat (gap) begin
        idleCycle();
      end
    end
    idleCycle();
    // Drain the pipeline
    waited = 0;
    while ((pending.size() != 0) && (waited < DRAIN_LIMIT)) begin
      @(posedge clk);
      waited++;
    end
    if (pending.size() != 0) begin
      $display("Timeout in %s: %0d results never left the pipeline", name, pending.size());
      timedOut = 1'b1;
    end
    $display("Test %s: %0d operations, %0d errors", name, count, testErrors);
    testCount++;
  endtask

  //////////////////////////////
  // Main sequence
  //////////////////////////////
  initial begin
    reset_i   = 1'b1;
    startOp_i = 1'b0;
    addSub_i  = 1'b0;
    dataX_i   = '0;
    dataY_i   = '0;
    repeat (4) @(posedge clk);
    reset_i <= 1'b0;
    // Quiet gap, any ready_o here is flagged
    repeat (4) begin
      idleCycle();
    end
    runTest("addRandom", opAdd, 60, 0);
    if (!timedOut) runTest("subRandom", opSub, 80, 0);
    if (!timedOut) runTest("cancelZero", opCancel, 20, 0);
    if (!timedOut) runTest("overflowHigh", opOverflow, 20, 0);
    if (!timedOut) runTest("underflowLow", opUnderflow, 20, 0);
    if (!timedOut) runTest("backToBack", opMixed, 80, 3);
    $display("Summary: %0d tests, %0d operations, %0d errors", testCount, opCount, errors);
    if ((errors == 0) && !timedOut) begin
      $display("Verification passed");
    end else begin
      $display("Verification failed");
    end
    $finish;
  end

endmodule

`default_nettype wire

/* build.f */
+incdir+sim
common/fpAddPkg.sv
design/operandSort.sv
design/alignStage.sv
design/significandAdder.sv
normalize/leadingZeroCount.sv
normalize/normalizeStage.sv
design/resultFormat.sv
design/fpAddSub.sv
sim/fpAddSubTb.sv

/* Makefile */
VERILATOR ?= verilator
VFLAGS    ?= --binary --assert --timing -j 0
TOP       ?= fpAddSubTb
FILELIST  ?= build.f
OBJDIR    ?= obj_dir
PASS_MSG  := Verification passed

.PHONY: help test clean

help:
	@echo "Targets:"
	@echo "  test   build with Verilator and run the testbench"
	@echo "  clean  remove the build directory"
	@echo "  help   show this list"

test:
	$(VERILATOR) $(VFLAGS) --top-module $(TOP) -f $(FILELIST) -Mdir $(OBJDIR)
	@out="$$(./$(OBJDIR)/V$(TOP))"; echo "$$out"; echo "$$out" | grep -q "$(PASS_MSG)"

clean:
	rm -rf $(OBJDIR)
